// File: source/usys_pkg.sv
`default_nettype none

package usys_pkg;

    // array geometry
    localparam int ARRAY_ROWS = 4;
    localparam int ARRAY_COLS = 4;

    // input feature is signed, weights arrive as sign plus magnitude
    localparam int IWIDTH    = 8;
    localparam int MAG_WIDTH = IWIDTH - 1;
    localparam int IFM_MAX   = 2 ** MAG_WIDTH - 1;

    // one unary stream covers every magnitude value
    localparam int STREAM_LEN = 2 ** MAG_WIDTH;
    localparam int CNT_WIDTH  = $clog2(STREAM_LEN);

    // room for four full-scale products, twice over when runs add up
    localparam int OWIDTH = 18;

    typedef logic signed [IWIDTH-1:0] ifm_t;
    typedef logic [MAG_WIDTH-1:0]     mag_t;
    typedef logic signed [OWIDTH-1:0] acc_t;
    typedef logic [CNT_WIDTH-1:0]     cnt_t;

    localparam cnt_t CNT_LAST = cnt_t'(STREAM_LEN - 1);

    // magnitude of a signed feature, valid for -127..127
    function automatic mag_t ifm_mag(input ifm_t v);
        ifm_t pos;
        pos = v[IWIDTH-1] ? -v : v;
        return pos[MAG_WIDTH-1:0];
    endfunction

    // one accumulation step, weight magnitude with the combined sign
    function automatic acc_t signed_term(input logic neg, input mag_t mag);
        acc_t term;
        term = acc_t'(mag);
        return neg ? -term : term;
    endfunction

endpackage

`default_nettype wire

// File: source/pe_link_if.sv
`timescale 1ns/1ps
`default_nettype none

// row bundle, travels left to right one column per cycle
interface ifm_link_if;

    logic en;
    logic clr;
    logic done;
    logic sign;
    // thermometer bit of the current stream cycle
    logic ubit;

    modport src (
        output en,
        output clr,
        output done,
        output sign,
        output ubit
    );

    modport dst (
        input en,
        input clr,
        input done,
        input sign,
        input ubit
    );

endinterface

// weight chain, travels top to bottom
interface wght_link_if;
    import usys_pkg::*;

    logic en;
    logic clr;
    logic sign;
    mag_t abs;

    modport src (
        output en,
        output clr,
        output sign,
        output abs
    );

    modport dst (
        input en,
        input clr,
        input sign,
        input abs
    );

endinterface

`default_nettype wire

// File: source/pe_inner.sv
`timescale 1ns/1ps
`default_nettype none

module pe_inner (
    input  logic           clk,
    input  logic           rst_i,
    ifm_link_if.dst        ifm_in,
    wght_link_if.dst       wght_in,
    input  logic           en_o_i,
    input  usys_pkg::acc_t ofm_i,
    ifm_link_if.src        ifm_out,
    wght_link_if.src       wght_out,
    output logic           en_o_o,
    output usys_pkg::acc_t ofm_o
);
    import usys_pkg::*;

    logic w_sign_q;
    mag_t w_abs_q;
    logic w_clr_q;

    acc_t acc_q;
    acc_t acc_nxt;
    acc_t result_q;
    logic mac_hit;

    // row bundle gets one register stage per column
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ifm_out.en   <= 1'b0;
            ifm_out.clr  <= 1'b0;
            ifm_out.done <= 1'b0;
            ifm_out.sign <= 1'b0;
            ifm_out.ubit <= 1'b0;
        end else begin
            ifm_out.en   <= ifm_in.en;
            ifm_out.clr  <= ifm_in.clr;
            ifm_out.done <= ifm_in.done;
            ifm_out.sign <= ifm_in.sign;
            ifm_out.ubit <= ifm_in.ubit;
        end
    end

    // weight register doubles as the shift chain stage
    always_ff @(posedge clk) begin
        if (rst_i) begin
            w_clr_q  <= 1'b0;
            w_sign_q <= 1'b0;
            w_abs_q  <= '0;
        end else begin
            w_clr_q <= wght_in.clr;
            if (wght_in.clr) begin
                w_sign_q <= 1'b0;
                w_abs_q  <= '0;
            end else if (wght_in.en) begin
                w_sign_q <= wght_in.sign;
                w_abs_q  <= wght_in.abs;
            end
        end
    end

    // shift enable reaches every row in the same cycle while clear walks down
    assign wght_out.en   = wght_in.en;
    assign wght_out.clr  = w_clr_q;
    assign wght_out.sign = w_sign_q;
    assign wght_out.abs  = w_abs_q;

    // temporal MAC adds one weight step per set input bit
    assign mac_hit = ifm_in.en && ifm_in.ubit;
    assign acc_nxt = mac_hit ? acc_q + signed_term(ifm_in.sign ^ w_sign_q, w_abs_q) : acc_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            acc_q    <= '0;
            result_q <= '0;
        end else begin
            if (ifm_in.clr) begin
                acc_q <= '0;
            end else begin
                acc_q <= acc_nxt;
            end
            // keep the finished sum on the last stream cycle
            if (ifm_in.en && ifm_in.done) begin
                result_q <= acc_nxt;
            end
        end
    end

    // output chain stage sums this row into the column total
    always_ff @(posedge clk) begin
        if (rst_i) begin
            en_o_o <= 1'b0;
            ofm_o  <= '0;
        end else begin
            en_o_o <= en_o_i;
            if (en_o_i) begin
                ofm_o <= result_q + ofm_i;
            end
        end
    end

    // done only inside a stream
    a_done_in_stream: assert property (
        @(posedge clk) disable iff (rst_i)
        ifm_in.done |-> ifm_in.en
    );

endmodule

`default_nettype wire

// File: source/pe_border.sv
`timescale 1ns/1ps
`default_nettype none

module pe_border (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           en_i_i,
    input  logic           clr_i_i,
    input  usys_pkg::ifm_t ifm_i,
    wght_link_if.dst       wght_in,
    input  logic           en_o_i,
    input  usys_pkg::acc_t ofm_i,
    ifm_link_if.src        ifm_out,
    wght_link_if.src       wght_out,
    output logic           en_o_o,
    output usys_pkg::acc_t ofm_o
);
    import usys_pkg::*;

    logic sign_q;
    mag_t mag_q;
    cnt_t cnt_q;
    logic active_q;

    // encoded stream into this column's own PE
    ifm_link_if enc_link ();

    // latch the feature, then count through one stream
    always_ff @(posedge clk) begin
        if (rst_i) begin
            sign_q   <= 1'b0;
            mag_q    <= '0;
            cnt_q    <= '0;
            active_q <= 1'b0;
        end else if (en_i_i) begin
            sign_q   <= ifm_i[IWIDTH-1];
            mag_q    <= ifm_mag(ifm_i);
            cnt_q    <= '0;
            active_q <= 1'b1;
        end else if (active_q) begin
            // wraps back to zero after the last count
            cnt_q <= cnt_q + cnt_t'(1);
            if (cnt_q == CNT_LAST) begin
                active_q <= 1'b0;
            end
        end
    end

    // thermometer code, high for the first mag_q cycles
    assign enc_link.en   = active_q;
    assign enc_link.clr  = clr_i_i;
    assign enc_link.done = active_q && (cnt_q == CNT_LAST);
    assign enc_link.sign = sign_q;
    assign enc_link.ubit = active_q && (cnt_q < mag_q);

    pe_inner u_pe_inner (
        .clk      (clk),
        .rst_i    (rst_i),
        .ifm_in   (enc_link),
        .wght_in  (wght_in),
        .en_o_i   (en_o_i),
        .ofm_i    (ofm_i),
        .ifm_out  (ifm_out),
        .wght_out (wght_out),
        .en_o_o   (en_o_o),
        .ofm_o    (ofm_o)
    );

    // -128 has no 7-bit magnitude
    a_ifm_range: assert property (
        @(posedge clk) disable iff (rst_i)
        en_i_i |-> (ifm_i >= -IFM_MAX)
    );

    // a new feature must wait for the running stream to end
    a_no_restart: assert property (
        @(posedge clk) disable iff (rst_i)
        en_i_i |-> !active_q
    );

endmodule

`default_nettype wire

// File: source/usys_array.sv
`timescale 1ns/1ps
`default_nettype none

module usys_array (
    input  logic                                                 clk,
    input  logic                                                 rst_i,
    input  logic [usys_pkg::ARRAY_ROWS-1:0]                      en_i_i,
    input  logic [usys_pkg::ARRAY_ROWS-1:0]                      clr_i_i,
    input  logic [usys_pkg::ARRAY_ROWS*usys_pkg::IWIDTH-1:0]     ifm_i,
    input  logic [usys_pkg::ARRAY_COLS-1:0]                      en_w_i,
    input  logic [usys_pkg::ARRAY_COLS-1:0]                      clr_w_i,
    input  logic [usys_pkg::ARRAY_COLS-1:0]                      wght_sign_i,
    input  logic [usys_pkg::ARRAY_COLS*usys_pkg::MAG_WIDTH-1:0]  wght_abs_i,
    input  logic [usys_pkg::ARRAY_COLS-1:0]                      en_o_i,
    output logic [usys_pkg::ARRAY_COLS*usys_pkg::OWIDTH-1:0]     ofm_o,
    output logic [usys_pkg::ARRAY_COLS-1:0]                      ofm_valid_o,
    output logic [usys_pkg::ARRAY_ROWS-1:0]                      row_done_o
);
    import usys_pkg::*;

    // row links, element r*ARRAY_COLS+c is the output of column c
    ifm_link_if ifm_link [ARRAY_ROWS*ARRAY_COLS] ();

    // column links, element c*(ARRAY_ROWS+1)+r is the input of row r
    wght_link_if wght_link [ARRAY_COLS*(ARRAY_ROWS+1)] ();

    // output chain, index r is the output of row r, top index enters row 3
    logic en_o_x [ARRAY_COLS][ARRAY_ROWS+1];
    acc_t ofm_x  [ARRAY_COLS][ARRAY_ROWS+1];

    ifm_t ifm_row [ARRAY_ROWS];

    for (genvar r = 0; r < ARRAY_ROWS; r++) begin : g_row_edge
        assign ifm_row[r] = ifm_t'(ifm_i[r*IWIDTH +: IWIDTH]);
        // done leaving the last column
        assign row_done_o[r] = ifm_link[r*ARRAY_COLS + ARRAY_COLS - 1].done;
    end

    for (genvar c = 0; c < ARRAY_COLS; c++) begin : g_col_edge
        assign wght_link[c*(ARRAY_ROWS+1)].en   = en_w_i[c];
        assign wght_link[c*(ARRAY_ROWS+1)].clr  = clr_w_i[c];
        assign wght_link[c*(ARRAY_ROWS+1)].sign = wght_sign_i[c];
        assign wght_link[c*(ARRAY_ROWS+1)].abs  = wght_abs_i[c*MAG_WIDTH +: MAG_WIDTH];

        assign en_o_x[c][ARRAY_ROWS] = en_o_i[c];
        assign ofm_x[c][ARRAY_ROWS]  = '0;

        assign ofm_o[c*OWIDTH +: OWIDTH] = ofm_x[c][0];
        assign ofm_valid_o[c]            = en_o_x[c][0];
    end

    for (genvar r = 0; r < ARRAY_ROWS; r++) begin : g_row
        pe_border u_pe_border (
            .clk      (clk),
            .rst_i    (rst_i),
            .en_i_i   (en_i_i[r]),
            .clr_i_i  (clr_i_i[r]),
            .ifm_i    (ifm_row[r]),
            .wght_in  (wght_link[r]),
            .en_o_i   (en_o_x[0][r+1]),
            .ofm_i    (ofm_x[0][r+1]),
            .ifm_out  (ifm_link[r*ARRAY_COLS]),
            .wght_out (wght_link[r+1]),
            .en_o_o   (en_o_x[0][r]),
            .ofm_o    (ofm_x[0][r])
        );

        for (genvar c = 1; c < ARRAY_COLS; c++) begin : g_col
            pe_inner u_pe_inner (
                .clk      (clk),
                .rst_i    (rst_i),
                .ifm_in   (ifm_link[r*ARRAY_COLS + c - 1]),
                .wght_in  (wght_link[c*(ARRAY_ROWS+1) + r]),
                .en_o_i   (en_o_x[c][r+1]),
                .ofm_i    (ofm_x[c][r+1]),
                .ifm_out  (ifm_link[r*ARRAY_COLS + c]),
                .wght_out (wght_link[c*(ARRAY_ROWS+1) + r + 1]),
                .en_o_o   (en_o_x[c][r]),
                .ofm_o    (ofm_x[c][r])
            );
        end
    end

endmodule

`default_nettype wire

// File: dv/usys_ref.svh
`ifndef USYS_REF_SVH
`define USYS_REF_SVH

// weights where they sit in the array, [column][row]
int exp_w [ARRAY_COLS][ARRAY_ROWS];
// features of the next stream, one per row
int exp_x [ARRAY_ROWS];
// column outputs the next readout must show
int exp_ofm [ARRAY_COLS];

// one load cycle, row 0 takes the new value and the rest move down
function automatic void shift_weight(input int c, input int w);
    for (int r = ARRAY_ROWS - 1; r > 0; r--) begin
        exp_w[c][r] = exp_w[c][r-1];
    end
    exp_w[c][0] = w;
endfunction

function automatic void clear_weight_model();
    for (int c = 0; c < ARRAY_COLS; c++) begin
        for (int r = 0; r < ARRAY_ROWS; r++) begin
            exp_w[c][r] = 0;
        end
    end
endfunction

// plain integer dot product of one column
function automatic int col_dot(input int c);
    int sum;
    sum = 0;
    for (int r = 0; r < ARRAY_ROWS; r++) begin
        sum += exp_x[r] * exp_w[c][r];
    end
    return sum;
endfunction

// a stream either starts a new sum or adds to the one held
function automatic void update_ofm(input bit restart);
    for (int c = 0; c < ARRAY_COLS; c++) begin
        exp_ofm[c] = restart ? col_dot(c) : exp_ofm[c] + col_dot(c);
    end
endfunction

`endif

// File: dv/tb_usys_array.sv
`timescale 1ns/1ps
`default_nettype none

module tb_usys_array;
    import usys_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int DRIVE_DLY  = 1;
    localparam int SEED       = 32'h57b5_9047;
    localparam int N_ROUNDS   = 6;
    // known values, random rounds, two without clr, clear and reload
    localparam int NUM_STREAMS    = N_ROUNDS + 5;
    localparam int TIMEOUT_CYCLES = NUM_STREAMS * (STREAM_LEN + 40) + 100;

    logic                            clk;
    logic                            rst_i;
    logic [ARRAY_ROWS-1:0]           en_i_i;
    logic [ARRAY_ROWS-1:0]           clr_i_i;
    logic [ARRAY_ROWS*IWIDTH-1:0]    ifm_i;
    logic [ARRAY_COLS-1:0]           en_w_i;
    logic [ARRAY_COLS-1:0]           clr_w_i;
    logic [ARRAY_COLS-1:0]           wght_sign_i;
    logic [ARRAY_COLS*MAG_WIDTH-1:0] wght_abs_i;
    logic [ARRAY_COLS-1:0]           en_o_i;
    logic [ARRAY_COLS*OWIDTH-1:0]    ofm_o;
    logic [ARRAY_COLS-1:0]           ofm_valid_o;
    logic [ARRAY_ROWS-1:0]           row_done_o;

    logic stream_seen;
    logic out_seen;
    int   valid_seen = 0;
    // weights in load order, [column][cycle]
    int   w_load [ARRAY_COLS][ARRAY_ROWS];

    `include "usys_ref.svh"

    usys_array UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_error(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // extremes and zero show up often on purpose
    function automatic int rand_value();
        int v;
        case ($urandom_range(0, 7))
            0: v = IFM_MAX;
            1: v = -IFM_MAX;
            2: v = 0;
            default: v = int'($urandom_range(0, 2 * IFM_MAX)) - IFM_MAX;
        endcase
        return v;
    endfunction

    task automatic pick_random();
        for (int r = 0; r < ARRAY_ROWS; r++) begin
            exp_x[r] = rand_value();
        end
        for (int c = 0; c < ARRAY_COLS; c++) begin
            for (int k = 0; k < ARRAY_ROWS; k++) begin
                w_load[c][k] = rand_value();
            end
        end
    endtask

    task automatic load_weights();
        int w;
        en_w_i = '1;
        for (int k = 0; k < ARRAY_ROWS; k++) begin
            for (int c = 0; c < ARRAY_COLS; c++) begin
                w = w_load[c][k];
                wght_sign_i[c] = (w < 0);
                wght_abs_i[c*MAG_WIDTH +: MAG_WIDTH] = mag_t'(w < 0 ? -w : w);
                shift_weight(c, w);
            end
            next_cycle();
        end
        en_w_i = '0;
    endtask

    // the clear walks down one row per cycle
    task automatic clear_weights();
        clr_w_i = '1;
        next_cycle();
        clr_w_i = '0;
        repeat (ARRAY_ROWS) next_cycle();
        clear_weight_model();
    endtask

    task automatic run_stream(input logic restart);
        logic [ARRAY_ROWS-1:0] seen;
        seen = '0;
        if (restart) begin
            clr_i_i = '1;
            next_cycle();
            clr_i_i = '0;
        end
        stream_seen = 1'b1;
        en_i_i = '1;
        for (int r = 0; r < ARRAY_ROWS; r++) begin
            ifm_i[r*IWIDTH +: IWIDTH] = ifm_t'(exp_x[r]);
        end
        next_cycle();
        en_i_i = '0;
        while (seen != '1) begin
            next_cycle();
            seen |= row_done_o;
        end
        update_ofm(restart);
    endtask

    task automatic read_out();
        out_seen = 1'b1;
        en_o_i = '1;
        next_cycle();
        en_o_i = '0;
        while (ofm_valid_o != '1) begin
            next_cycle();
        end
        // one more edge so the checker samples the valid cycle
        next_cycle();
    endtask

    initial begin
        clk = 1'b0;
        rst_i = 1'b1;
        en_i_i = '0;
        clr_i_i = '0;
        ifm_i = '0;
        en_w_i = '0;
        clr_w_i = '0;
        wght_sign_i = '0;
        wght_abs_i = '0;
        en_o_i = '0;
        stream_seen = 1'b0;
        out_seen = 1'b0;
        void'($urandom(SEED));
        repeat (3) next_cycle();
        rst_i = 1'b0;
        repeat (10) next_cycle();

        // fixed values, each column loaded in a different order
        w_load[0] = '{127, -127, 0, 3};
        w_load[1] = '{1, 2, 3, 4};
        w_load[2] = '{-5, 60, -90, 11};
        w_load[3] = '{-127, -127, 127, 127};
        exp_x = '{127, -127, 0, 45};
        load_weights();
        run_stream(1'b1);
        read_out();

        for (int i = 0; i < N_ROUNDS; i++) begin
            pick_random();
            load_weights();
            run_stream(1'b1);
            read_out();
        end

        // second stream adds onto the first
        pick_random();
        run_stream(1'b1);
        read_out();
        pick_random();
        run_stream(1'b0);
        read_out();

        // zero after the clear, then the new weights after a full shift
        clear_weights();
        pick_random();
        run_stream(1'b1);
        read_out();
        load_weights();
        run_stream(1'b1);
        read_out();

        if (valid_seen != NUM_STREAMS * ARRAY_COLS) begin
            $display("only %0d of %0d column outputs were checked", valid_seen,
                     NUM_STREAMS * ARRAY_COLS);
            $display("TESTS FAILED");
            $fatal(1, "output checks missing");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("the run timed out after %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    always @(posedge clk) begin
        if (!rst_i) begin
            valid_seen <= valid_seen + $countones(ofm_valid_o);
        end
    end

    a_quiet_out: assert property (@(posedge clk) disable iff (rst_i)
        !out_seen |-> (ofm_valid_o == '0 && ofm_o == '0))
        else report_error("output active before the first en_o_i");

    a_quiet_rows: assert property (@(posedge clk) disable iff (rst_i)
        !stream_seen |-> (row_done_o == '0))
        else report_error("row_done_o high before any stream");

    for (genvar c = 0; c < ARRAY_COLS; c++) begin : g_col_chk
        a_valid_latency: assert property (@(posedge clk) disable iff (rst_i)
            ofm_valid_o[c] == $past(en_o_i[c], 4))
            else report_error($sformatf("column %0d valid not 4 cycles after en_o_i", c));

        a_ofm_value: assert property (@(posedge clk) disable iff (rst_i)
            ofm_valid_o[c] |-> ($signed(ofm_o[c*OWIDTH +: OWIDTH]) == exp_ofm[c]))
            else report_error($sformatf("column %0d output %0d, expected %0d", c,
                $signed(ofm_o[c*OWIDTH +: OWIDTH]), exp_ofm[c]));
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+dv
source/usys_pkg.sv
source/pe_link_if.sv
source/pe_inner.sv
source/pe_border.sv
source/usys_array.sv
dv/tb_usys_array.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, and judge the run by its log
cd "$(dirname "$0")" || exit 1
log=sim.log
{ verilator --binary --assert -j 0 --top-module tb_usys_array -f tb.f \
    && ./obj_dir/Vtb_usys_array; } > "$log" 2>&1 \
    || echo "build or simulation ended with an error, TESTS FAILED" >> "$log"
cat "$log"
grep -q "TESTS FAILED" "$log" && exit 1 || exit 0
